//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Data and address word
	typedef logic [15:0] word;

	// One of sixteen general registers
	typedef logic [3:0] regIdx;

	// Major opcode, instruction bits 15..12
	typedef enum logic [3:0] {
		opAdd  = 4'h0,
		opSub  = 4'h1,
		opXor  = 4'h2,
		opAnd  = 4'h3,
		opSll  = 4'h4,
		opSra  = 4'h5,
		opRor  = 4'h6,
		opNop  = 4'h7,
		opLw   = 4'h8,
		opSw   = 4'h9,
		opLlb  = 4'hA,
		opLhb  = 4'hB,
		opBr   = 4'hC,
		// Spare codes, executed as no-ops
		opNopD = 4'hD,
		opNopE = 4'hE,
		opHlt  = 4'hF
	} opcode;

	// Branch condition, instruction bits 11..9
	typedef enum logic [2:0] {
		ccNe = 3'd0,
		ccEq = 3'd1,
		ccGt = 3'd2,
		ccLt = 3'd3,
		ccGe = 3'd4,
		ccLe = 3'd5,
		ccOv = 3'd6,
		ccUn = 3'd7
	} condCode;

	// Negative, overflow, zero
	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags;

	// ALU function, low codes line up with opcodes 0..6
	typedef enum logic [2:0] {
		aluAdd, aluSub, aluXor, aluAnd, aluSll, aluSra, aluRor, aluPass
	} aluOp;

	// Operand source in execute
	typedef enum logic [1:0] {
		fwdRegfile = 2'd0,
		fwdFromMem = 2'd1,
		fwdFromWb  = 2'd2
	} fwdSel;

	// Bubble word placed in IF/ID
	localparam word nopInstr = {opNop, 12'h000};

endpackage

`default_nettype wire

//--- source/exMemIf.sv
`timescale 1ns/1ps
`default_nettype none

// EX/MEM pipeline register contents
interface exMemIf ();

	// Payload
	cpuPkg::word aluOut;
	cpuPkg::word storeData;
	cpuPkg::regIdx dst;

	// Controls
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic halt;

	// Execute owns the register
	modport producer (
		output aluOut, storeData, dst, regWrite, memRead, memWrite, halt
	);

	// Memory stage side
	modport consumer (
		input aluOut, storeData, dst, regWrite, memRead, memWrite, halt
	);

	// Forwarding taps
	modport monitor (input dst, aluOut, regWrite);

endinterface

`default_nettype wire

//--- source/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch (
	input wire clk,
	input wire rstN,
	input wire stall,
	input wire halting,
	input wire branchTaken,
	input wire cpuPkg::word branchTarget,
	output cpuPkg::word imemAddr,
	input wire cpuPkg::word imemData,
	output cpuPkg::word instrId,
	output cpuPkg::word pcPlusOneId
);

	cpuPkg::word pc;
	cpuPkg::word pcPlusOne;

	assign pcPlusOne = pc + 16'd1;
	// Instruction memory answers in the same cycle
	assign imemAddr = pc;

	// Branch wins, then hold, else sequential
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else if (!stall && !halting) begin
			pc <= pcPlusOne;
		end
	end

	// IF/ID instruction, squashed behind a taken branch
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrId <= cpuPkg::nopInstr;
		end else if (branchTaken) begin
			instrId <= cpuPkg::nopInstr;
		end else if (!stall && !halting) begin
			instrId <= imemData;
		end
	end

	// Return address for branch target math
	always_ff @(posedge clk) begin
		if (!stall && !halting) begin
			pcPlusOneId <= pcPlusOne;
		end
	end

	// Stall from hazard unit must freeze the PC
	pcHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(pc));

endmodule

`default_nettype wire

//--- source/hazardDetection.sv
`timescale 1ns/1ps
`default_nettype none

module hazardDetection (
	input wire cpuPkg::regIdx srcA,
	input wire cpuPkg::regIdx srcB,
	input wire usesA,
	input wire usesB,
	input wire isBranch,
	input wire exMemRead,
	input wire cpuPkg::regIdx exDst,
	input wire exSetsFlags,
	output logic stall
);

	logic hitA;
	logic hitB;
	logic loadUse;
	logic flagWait;

	// Source match against the load in execute
	assign hitA = usesA && (srcA == exDst);
	assign hitB = usesB && (srcB == exDst);

	// Loaded word only exists after MEM, so wait one slot
	assign loadUse = exMemRead && (hitA || hitB);

	// Flags land at the end of execute
	assign flagWait = isBranch && exSetsFlags;

	assign stall = loadUse || flagWait;

endmodule

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
	input wire clk,
	input wire rstN,
	input wire stall,
	input wire cpuPkg::word instrId,
	input wire cpuPkg::word pcPlusOneId,
	input wire cpuPkg::flags curFlags,
	input wire wbWrite,
	input wire cpuPkg::regIdx wbDst,
	input wire cpuPkg::word wbData,
	output logic branchTaken,
	output cpuPkg::word branchTarget,
	output cpuPkg::regIdx srcA,
	output cpuPkg::regIdx srcB,
	output logic usesA,
	output logic usesB,
	output logic isBranch,
	output logic halting,
	output cpuPkg::aluOp exOp,
	output cpuPkg::word exOperandA,
	output cpuPkg::word exOperandB,
	output cpuPkg::word exImm,
	output logic exUseImm,
	output cpuPkg::regIdx exSrcA,
	output cpuPkg::regIdx exSrcB,
	output cpuPkg::regIdx exDst,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exSetsFlags,
	output logic exHalt
);

	cpuPkg::opcode op;
	cpuPkg::condCode cond;
	cpuPkg::word regs [16];
	cpuPkg::word readA;
	cpuPkg::word readB;
	cpuPkg::word imm;
	cpuPkg::aluOp fn;
	logic useImm;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic setsFlags;
	logic condTrue;

	assign op = cpuPkg::opcode'(instrId[15:12]);
	assign cond = cpuPkg::condCode'(instrId[11:9]);
	assign isBranch = (op == cpuPkg::opBr);
	assign halting = (op == cpuPkg::opHlt);

	// Control decode
	always_comb begin
		fn = cpuPkg::aluPass;
		useImm = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		setsFlags = 1'b0;
		usesA = 1'b0;
		usesB = 1'b0;
		srcA = instrId[7:4];
		srcB = instrId[3:0];
		// Shift amount, zero-extended
		imm = {12'h000, instrId[3:0]};
		case (op)
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opXor, cpuPkg::opAnd: begin
				// Opcode low bits are the ALU code
				fn = cpuPkg::aluOp'(instrId[14:12]);
				usesA = 1'b1;
				usesB = 1'b1;
				regWrite = 1'b1;
				setsFlags = 1'b1;
			end
			cpuPkg::opSll, cpuPkg::opSra, cpuPkg::opRor: begin
				fn = cpuPkg::aluOp'(instrId[14:12]);
				usesA = 1'b1;
				useImm = 1'b1;
				regWrite = 1'b1;
				setsFlags = 1'b1;
			end
			cpuPkg::opLw, cpuPkg::opSw: begin
				// Base plus signed 4-bit offset
				fn = cpuPkg::aluAdd;
				imm = {{12{instrId[3]}}, instrId[3:0]};
				usesA = 1'b1;
				useImm = 1'b1;
				regWrite = (op == cpuPkg::opLw);
				memRead = (op == cpuPkg::opLw);
				memWrite = (op == cpuPkg::opSw);
				// Store data comes from rd
				usesB = (op == cpuPkg::opSw);
				srcB = instrId[11:8];
			end
			cpuPkg::opLlb: begin
				imm = {8'h00, instrId[7:0]};
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::opLhb: begin
				// Old rd supplies the low byte, so no full immediate
				imm = {instrId[7:0], 8'h00};
				srcA = instrId[11:8];
				usesA = 1'b1;
				regWrite = 1'b1;
			end
			default: begin
				// BR, HLT and spare codes write nothing
			end
		endcase
	end

	// Register file, same-cycle write seen by the read
	assign readA = (wbWrite && wbDst == srcA) ? wbData : regs[srcA];
	assign readB = (wbWrite && wbDst == srcB) ? wbData : regs[srcB];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite) begin
			regs[wbDst] <= wbData;
		end
	end

	// Condition test on committed flags
	always_comb begin
		case (cond)
			cpuPkg::ccNe: condTrue = !curFlags.z;
			cpuPkg::ccEq: condTrue = curFlags.z;
			cpuPkg::ccGt: condTrue = !curFlags.z && !curFlags.n;
			cpuPkg::ccLt: condTrue = curFlags.n;
			cpuPkg::ccGe: condTrue = curFlags.z || !curFlags.n;
			cpuPkg::ccLe: condTrue = curFlags.z || curFlags.n;
			cpuPkg::ccOv: condTrue = curFlags.v;
			default: condTrue = 1'b1;
		endcase
	end

	// Signed 9-bit offset from PC plus one
	assign branchTarget = pcPlusOneId + {{7{instrId[8]}}, instrId[8:0]};
	// No redirect while waiting on flags
	assign branchTaken = isBranch && condTrue && !stall;

	// ID/EX controls, bubble on stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exSetsFlags <= 1'b0;
			exHalt <= 1'b0;
		end else if (stall) begin
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exSetsFlags <= 1'b0;
			exHalt <= 1'b0;
		end else begin
			exRegWrite <= regWrite;
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			exSetsFlags <= setsFlags;
			exHalt <= halting;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		exOp <= fn;
		exOperandA <= readA;
		exOperandB <= readB;
		exImm <= imm;
		exUseImm <= useImm;
		exSrcA <= srcA;
		exSrcB <= srcB;
		exDst <= instrId[11:8];
	end

endmodule

`default_nettype wire

//--- source/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
	input wire clk,
	input wire rstN,
	input wire cpuPkg::aluOp exOp,
	input wire cpuPkg::word exOperandA,
	input wire cpuPkg::word exOperandB,
	input wire cpuPkg::word exImm,
	input wire exUseImm,
	input wire cpuPkg::regIdx exSrcA,
	input wire cpuPkg::regIdx exSrcB,
	input wire cpuPkg::regIdx exDst,
	input wire exRegWrite,
	input wire exMemRead,
	input wire exMemWrite,
	input wire exSetsFlags,
	input wire exHalt,
	input wire wbWrite,
	input wire cpuPkg::regIdx wbDst,
	input wire cpuPkg::word wbData,
	output cpuPkg::flags curFlags,
	exMemIf.producer exMem,
	exMemIf.monitor exMon
);

	cpuPkg::fwdSel selA;
	cpuPkg::fwdSel selB;
	cpuPkg::word opA;
	cpuPkg::word fwdB;
	cpuPkg::word opB;
	cpuPkg::word result;
	cpuPkg::flags newFlags;
	logic [31:0] rotated;

	// Youngest producer first
	function automatic cpuPkg::fwdSel pickSource(
		input cpuPkg::regIdx src,
		input logic memWr,
		input cpuPkg::regIdx memDst,
		input logic wbWr,
		input cpuPkg::regIdx wbD
	);
		if (memWr && memDst == src) begin
			return cpuPkg::fwdFromMem;
		end else if (wbWr && wbD == src) begin
			return cpuPkg::fwdFromWb;
		end
		return cpuPkg::fwdRegfile;
	endfunction

	assign selA = pickSource(exSrcA, exMon.regWrite, exMon.dst, wbWrite, wbDst);
	assign selB = pickSource(exSrcB, exMon.regWrite, exMon.dst, wbWrite, wbDst);

	always_comb begin
		case (selA)
			cpuPkg::fwdFromMem: opA = exMon.aluOut;
			cpuPkg::fwdFromWb: opA = wbData;
			default: opA = exOperandA;
		endcase
		case (selB)
			cpuPkg::fwdFromMem: fwdB = exMon.aluOut;
			cpuPkg::fwdFromWb: fwdB = wbData;
			default: fwdB = exOperandB;
		endcase
	end

	assign opB = exUseImm ? exImm : fwdB;

	// ALU and flag generation
	always_comb begin
		rotated = {opA, opA} >> opB[3:0];
		newFlags = curFlags;
		case (exOp)
			cpuPkg::aluAdd: begin
				result = opA + opB;
				newFlags.v = (opA[15] == opB[15]) && (result[15] != opA[15]);
			end
			cpuPkg::aluSub: begin
				result = opA - opB;
				newFlags.v = (opA[15] != opB[15]) && (result[15] != opA[15]);
			end
			cpuPkg::aluXor: result = opA ^ opB;
			cpuPkg::aluAnd: result = opA & opB;
			cpuPkg::aluSll: result = opA << opB[3:0];
			cpuPkg::aluSra: result = $signed(opA) >>> opB[3:0];
			cpuPkg::aluRor: result = rotated[15:0];
			// LLB takes the whole immediate, LHB keeps the old low byte
			default: result = {exImm[15:8], exUseImm ? exImm[7:0] : opA[7:0]};
		endcase
		newFlags.z = (result == '0);
		// n only from arithmetic
		if (exOp == cpuPkg::aluAdd || exOp == cpuPkg::aluSub) begin
			newFlags.n = result[15];
		end
	end

	// Flag register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			curFlags <= '0;
		end else if (exSetsFlags) begin
			curFlags <= newFlags;
		end
	end

	// EX/MEM controls
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.halt <= 1'b0;
		end else begin
			exMem.regWrite <= exRegWrite;
			exMem.memRead <= exMemRead;
			exMem.memWrite <= exMemWrite;
			exMem.halt <= exHalt;
		end
	end

	// EX/MEM payload, store data is the forwarded rd
	always_ff @(posedge clk) begin
		exMem.aluOut <= result;
		exMem.storeData <= fwdB;
		exMem.dst <= exDst;
	end

	// Forwarded value must come from a stage that really writes
	fwdFromWriter: assert property (@(posedge clk) disable iff (!rstN)
		!((selA == cpuPkg::fwdFromMem || selB == cpuPkg::fwdFromMem) && !exMon.regWrite) &&
		!((selA == cpuPkg::fwdFromWb || selB == cpuPkg::fwdFromWb) && !wbWrite));

endmodule

`default_nettype wire

//--- source/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
	parameter int dmemAddrBits = 8
) (
	input wire clk,
	input wire rstN,
	exMemIf.consumer exMem,
	output logic wbWrite,
	output cpuPkg::regIdx wbDst,
	output cpuPkg::word wbData,
	output logic hlt
);

	localparam int depth = 2 ** dmemAddrBits;

	cpuPkg::word dmem [depth];
	logic [dmemAddrBits-1:0] addr;
	cpuPkg::word loadData;

	// Word address from the low ALU bits
	assign addr = exMem.aluOut[dmemAddrBits-1:0];
	// Combinational read inside MEM
	assign loadData = dmem[addr];

	// Data memory, cleared at reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < depth; i++) begin
				dmem[i] <= '0;
			end
		end else if (exMem.memWrite) begin
			dmem[addr] <= exMem.storeData;
		end
	end

	// MEM/WB controls, hlt sticks until reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbWrite <= 1'b0;
			hlt <= 1'b0;
		end else begin
			wbWrite <= exMem.regWrite;
			if (exMem.halt) begin
				hlt <= 1'b1;
			end
		end
	end

	// Write-back select folded into MEM/WB
	always_ff @(posedge clk) begin
		wbDst <= exMem.dst;
		wbData <= exMem.memRead ? loadData : exMem.aluOut;
	end

	memRdWrExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(exMem.memRead && exMem.memWrite));

endmodule

`default_nettype wire

//--- source/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter int dmemAddrBits = 8
) (
	input wire clk,
	input wire rstN,
	output cpuPkg::word imemAddr,
	input wire cpuPkg::word imemData,
	output cpuPkg::word pc,
	output logic hlt,
	output logic retireValid,
	output cpuPkg::regIdx retireReg,
	output cpuPkg::word retireData
);

	// Fetch and hazard
	logic stall;
	logic halting;
	logic branchTaken;
	cpuPkg::word branchTarget;
	cpuPkg::word instrId;
	cpuPkg::word pcPlusOneId;

	// Decode side
	cpuPkg::regIdx srcA, srcB;
	logic usesA, usesB, isBranch;
	cpuPkg::flags curFlags;

	// ID/EX
	cpuPkg::aluOp exOp;
	cpuPkg::word exOperandA, exOperandB, exImm;
	cpuPkg::regIdx exSrcA, exSrcB, exDst;
	logic exUseImm, exRegWrite, exMemRead, exMemWrite, exSetsFlags, exHalt;

	// Write-back
	logic wbWrite;
	cpuPkg::regIdx wbDst;
	cpuPkg::word wbData;

	exMemIf exMemBus ();

	fetch u_fetch (.clk(clk), .rstN(rstN), .stall(stall), .halting(halting),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .imemAddr(imemAddr),
		.imemData(imemData), .instrId(instrId), .pcPlusOneId(pcPlusOneId));

	hazardDetection u_hazard (.srcA(srcA), .srcB(srcB), .usesA(usesA), .usesB(usesB),
		.isBranch(isBranch), .exMemRead(exMemRead), .exDst(exDst),
		.exSetsFlags(exSetsFlags), .stall(stall));

	decode u_decode (.clk(clk), .rstN(rstN), .stall(stall), .instrId(instrId),
		.pcPlusOneId(pcPlusOneId), .curFlags(curFlags), .wbWrite(wbWrite),
		.wbDst(wbDst), .wbData(wbData), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .srcA(srcA), .srcB(srcB), .usesA(usesA),
		.usesB(usesB), .isBranch(isBranch), .halting(halting), .exOp(exOp),
		.exOperandA(exOperandA), .exOperandB(exOperandB), .exImm(exImm),
		.exUseImm(exUseImm), .exSrcA(exSrcA), .exSrcB(exSrcB), .exDst(exDst),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
		.exSetsFlags(exSetsFlags), .exHalt(exHalt));

	// Same bundle twice, once to drive and once to tap for forwarding
	execute u_execute (.clk(clk), .rstN(rstN), .exOp(exOp), .exOperandA(exOperandA),
		.exOperandB(exOperandB), .exImm(exImm), .exUseImm(exUseImm), .exSrcA(exSrcA),
		.exSrcB(exSrcB), .exDst(exDst), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exSetsFlags(exSetsFlags), .exHalt(exHalt),
		.wbWrite(wbWrite), .wbDst(wbDst), .wbData(wbData), .curFlags(curFlags),
		.exMem(exMemBus.producer), .exMon(exMemBus.monitor));

	memoryStage #(.dmemAddrBits(dmemAddrBits)) u_memory (.clk(clk), .rstN(rstN),
		.exMem(exMemBus.consumer), .wbWrite(wbWrite), .wbDst(wbDst), .wbData(wbData),
		.hlt(hlt));

	assign pc = imemAddr;

	// Every register write retires here
	assign retireValid = wbWrite;
	assign retireReg = wbDst;
	assign retireData = wbData;

endmodule

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int progCount = 8;
	localparam int progLen = 64;
	localparam int resetCycles = 5;
	localparam int quietCycles = 8;
	// At most a stall or a squash per slot plus pipeline drain
	localparam int watchdogCycles =
		progCount * (progLen * 3 + 40 + resetCycles + quietCycles + 2);

	logic clk;
	logic rstN;
	cpuPkg::word imemAddr;
	cpuPkg::word imemData;
	cpuPkg::word pc;
	logic hlt;
	logic retireValid;
	cpuPkg::regIdx retireReg;
	cpuPkg::word retireData;

	cpuPkg::word prog [progLen];
	logic [31:0] rngState;

	// Instruction-set model state
	cpuPkg::word modelRegs [16];
	cpuPkg::word modelMem [256];
	cpuPkg::flags modelFlags;
	cpuPkg::regIdx expReg [$];
	cpuPkg::word expData [$];
	// Address after the model's HLT
	cpuPkg::word expPc;

	cpu #(.dmemAddrBits(8)) u_cpu (.clk(clk), .rstN(rstN), .imemAddr(imemAddr),
		.imemData(imemData), .pc(pc), .hlt(hlt), .retireValid(retireValid),
		.retireReg(retireReg), .retireData(retireData));

	// Instruction ROM with HLT past the end
	assign imemData = (imemAddr < 16'(progLen)) ? prog[imemAddr[5:0]] : {cpuPkg::opHlt, 12'h000};

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// LCG step returning the better-mixed upper half
	function automatic logic [15:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState[31:16];
	endfunction

	function automatic int randBelow(int n);
		return int'(nextRand()) % n;
	endfunction

	function automatic cpuPkg::regIdx pickReg();
		logic [15:0] r;
		r = nextRand();
		// Mostly r0..r3 so dependencies are dense
		if (r[15:14] != 2'b00) begin
			return {2'b00, r[1:0]};
		end
		return r[3:0];
	endfunction

	function automatic cpuPkg::word rotateRight(cpuPkg::word v, logic [3:0] n);
		cpuPkg::word out;
		out = v;
		// Bit 0 wraps to bit 15 on every step
		for (int k = 0; k < 16; k++) begin
			if (k < int'(n)) begin
				out = {out[0], out[15:1]};
			end
		end
		return out;
	endfunction

	function automatic logic condHolds(cpuPkg::condCode cc, cpuPkg::flags f);
		case (cc)
			cpuPkg::ccNe: return !f.z;
			cpuPkg::ccEq: return f.z;
			cpuPkg::ccGt: return !f.z && !f.n;
			cpuPkg::ccLt: return f.n;
			cpuPkg::ccGe: return f.z || !f.n;
			cpuPkg::ccLe: return f.z || f.n;
			cpuPkg::ccOv: return f.v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic buildProgram();
		int i;
		int kind;
		int maxOff;
		logic [15:0] r;
		cpuPkg::regIdx ra;
		cpuPkg::regIdx rb;
		cpuPkg::regIdx rc;
		cpuPkg::opcode nopCode;
		i = 0;
		while (i < progLen - 1) begin
			kind = randBelow(16);
			r = nextRand();
			ra = pickReg();
			rb = pickReg();
			rc = pickReg();
			if (kind <= 3) begin
				prog[i] = {cpuPkg::opcode'(kind[3:0]), ra, rb, rc};
			end else if (kind <= 6) begin
				// Shift amount over the full 0..15 range
				prog[i] = {cpuPkg::opcode'(kind[3:0]), ra, rb, r[3:0]};
			end else if (kind == 7 || kind == 9) begin
				prog[i] = {cpuPkg::opLlb, ra, r[7:0]};
			end else if (kind == 8) begin
				prog[i] = {cpuPkg::opLhb, ra, r[15:8]};
			end else if ((kind == 10 || kind == 11) && i <= progLen - 4) begin
				// Store and reload of the same word followed by an immediate use
				prog[i] = {cpuPkg::opSw, ra, rb, r[3:0]};
				prog[i + 1] = {cpuPkg::opLw, rc, rb, r[3:0]};
				prog[i + 2] = {cpuPkg::opAdd, ra, rc, ra};
				i = i + 2;
			end else if (kind >= 10 && kind <= 12) begin
				prog[i] = {r[4] ? cpuPkg::opSw : cpuPkg::opLw, ra, rb, r[3:0]};
			end else if (kind <= 14) begin
				// Forward only and never past the HLT slot
				maxOff = progLen - 2 - i;
				if (maxOff > 7) begin
					maxOff = 7;
				end
				prog[i] = {cpuPkg::opBr, r[11:9], 9'(randBelow(maxOff + 1))};
			end else begin
				case (r[1:0])
					2'd0: nopCode = cpuPkg::opNop;
					2'd1: nopCode = cpuPkg::opNopD;
					default: nopCode = cpuPkg::opNopE;
				endcase
				prog[i] = {nopCode, r[15:4]};
			end
			i++;
		end
		prog[progLen - 1] = {cpuPkg::opHlt, 12'h000};
	endtask

	task automatic writeReg(cpuPkg::regIdx rd, cpuPkg::word val);
		modelRegs[rd] = val;
		expReg.push_back(rd);
		expData.push_back(val);
	endtask

	// Runs the loaded program one instruction at a time up to HLT
	task automatic runModel();
		cpuPkg::word mpc;
		cpuPkg::word instr;
		cpuPkg::opcode op;
		cpuPkg::regIdx rd;
		cpuPkg::word a;
		cpuPkg::word b;
		cpuPkg::word r;
		cpuPkg::word sum;
		logic [3:0] rt;
		logic aluWrite;
		logic done;
		int steps;
		int wide;
		for (int k = 0; k < 16; k++) begin
			modelRegs[k] = '0;
		end
		for (int k = 0; k < 256; k++) begin
			modelMem[k] = '0;
		end
		modelFlags = '0;
		expReg.delete();
		expData.delete();
		mpc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < progLen) begin
			instr = prog[mpc[5:0]];
			op = cpuPkg::opcode'(instr[15:12]);
			rd = instr[11:8];
			rt = instr[3:0];
			a = modelRegs[instr[7:4]];
			b = modelRegs[rt];
			mpc = mpc + 16'd1;
			steps++;
			r = '0;
			aluWrite = 1'b1;
			case (op)
				cpuPkg::opAdd: begin
					r = a + b;
					wide = int'($signed(a)) + int'($signed(b));
					modelFlags.n = r[15];
					// Signed sum outside the 16-bit range
					modelFlags.v = (wide > 32767) || (wide < -32768);
				end
				cpuPkg::opSub: begin
					r = a - b;
					wide = int'($signed(a)) - int'($signed(b));
					modelFlags.n = r[15];
					modelFlags.v = (wide > 32767) || (wide < -32768);
				end
				cpuPkg::opXor: r = a ^ b;
				cpuPkg::opAnd: r = a & b;
				cpuPkg::opSll: r = a << rt;
				cpuPkg::opSra: r = $signed(a) >>> rt;
				cpuPkg::opRor: r = rotateRight(a, rt);
				default: aluWrite = 1'b0;
			endcase
			if (aluWrite) begin
				modelFlags.z = (r == '0);
				writeReg(rd, r);
			end
			// Effective address with a sign-extended 4-bit offset
			sum = a + {{12{rt[3]}}, rt};
			case (op)
				cpuPkg::opLw: writeReg(rd, modelMem[sum[7:0]]);
				cpuPkg::opSw: modelMem[sum[7:0]] = modelRegs[rd];
				cpuPkg::opLlb: writeReg(rd, {8'h00, instr[7:0]});
				cpuPkg::opLhb: writeReg(rd, {instr[7:0], modelRegs[rd][7:0]});
				cpuPkg::opBr: begin
					if (condHolds(cpuPkg::condCode'(instr[11:9]), modelFlags)) begin
						mpc = mpc + {{7{instr[8]}}, instr[8:0]};
					end
				end
				cpuPkg::opHlt: done = 1'b1;
				default: begin
				end
			endcase
		end
		expPc = mpc;
	endtask

	task automatic checkRetire(string name, cpuPkg::regIdx expR, cpuPkg::word expD,
		cpuPkg::regIdx actR, cpuPkg::word actD);
		if (expR !== actR || expD !== actD) begin
			$display("ERR %s expected r%0d=%h actual r%0d=%h", name, expR, expD, actR, actD);
			abortRun("retired register write differs from the model");
		end
	endtask

	task automatic checkHalt(string name, int expCount, int actCount, logic hltNow);
		if (hltNow !== 1'b1 || expCount != actCount) begin
			$display("ERR %s expected hlt=1 writes=%0d actual hlt=%b writes=%0d",
				name, expCount, hltNow, actCount);
			abortRun("halt state or write count is wrong");
		end
	endtask

	task automatic checkPc(string name, cpuPkg::word expP, cpuPkg::word actP);
		if (expP !== actP) begin
			$display("ERR %s expected pc=%h actual pc=%h", name, expP, actP);
			abortRun("program counter after halt differs from the model");
		end
	endtask

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		abortRun("watchdog expired before all programs halted");
	end

	initial begin
		string name;
		int retired;
		rstN = 1'b0;
		rngState = 32'h976fdd54;
		for (int k = 0; k < progLen; k++) begin
			prog[k] = {cpuPkg::opHlt, 12'h000};
		end
		for (int p = 0; p < progCount; p++) begin
			@(negedge clk);
			rstN = 1'b0;
			buildProgram();
			runModel();
			name = $sformatf("prog%0d", p);
			repeat (resetCycles) @(negedge clk);
			rstN = 1'b1;
			retired = 0;
			// Retires compared in order until hlt shows up
			while (hlt !== 1'b1) begin
				@(negedge clk);
				if (retireValid === 1'b1) begin
					if (retired >= expReg.size()) begin
						abortRun($sformatf("%s retired more writes than the model made", name));
					end else begin
						checkRetire(name, expReg[retired], expData[retired], retireReg, retireData);
						retired++;
					end
				end
			end
			checkHalt(name, expReg.size(), retired, hlt);
			// Fetch parks just past HLT
			checkPc(name, expPc, pc);
			// Nothing younger than HLT may retire
			repeat (quietCycles) begin
				@(negedge clk);
				if (retireValid !== 1'b0 || hlt !== 1'b1) begin
					abortRun($sformatf("%s wrote a register or dropped hlt after halt", name));
				end
				checkPc(name, expPc, pc);
			end
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/cpuPkg.sv
source/exMemIf.sv
source/fetch.sv
source/hazardDetection.sv
source/decode.sv
source/execute.sv
source/memoryStage.sv
source/cpu.sv
tests/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cpuTb -Mdir obj_dir -o cpuTbSim

./obj_dir/cpuTbSim 2>&1 | tee sim.log

grep -q "TB PASSED" sim.log
